// ==== list.f ====
+incdir+logic
logic/uart_reg_pkg.sv
logic/uart_line_pkg.sv
logic/uart_axil_regs.sv
logic/uart_tx_fifo.sv
logic/uart_tx_serializer.sv
logic/uart_tx_top.sv
tb/tb_clock_gen.sv
tb/tb_uart_tx.sv

// ==== logic/uart_axil_regs.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_axil_regs (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    // write address, data and response
    input  uart_reg_pkg::axil_addr_t   s_awaddr_i,
    input  logic                       s_awvalid_i,
    output logic                       s_awready_o,
    input  uart_reg_pkg::axil_data_t   s_wdata_i,
    input  logic                       s_wvalid_i,
    output logic                       s_wready_o,
    output uart_reg_pkg::axil_resp_t   s_bresp_o,
    output logic                       s_bvalid_o,
    input  logic                       s_bready_i,
    // read address and data
    input  uart_reg_pkg::axil_addr_t   s_araddr_i,
    input  logic                       s_arvalid_i,
    output logic                       s_arready_o,
    output uart_reg_pkg::axil_data_t   s_rdata_o,
    output uart_reg_pkg::axil_resp_t   s_rresp_o,
    output logic                       s_rvalid_o,
    input  logic                       s_rready_i,
    // FIFO and serializer flags
    input  logic                       fifo_full_i,
    input  logic                       fifo_empty_i,
    input  logic                       busy_i,
    input  logic                       frame_done_i,
    output logic                       push_o,
    output uart_line_pkg::frame_word_t push_data_o,
    output uart_reg_pkg::ctrl_t        ctrl_o,
    output uart_line_pkg::baud_acc_t   baud_o
);

    uart_reg_pkg::ctrl_t      ctrl_q;
    uart_line_pkg::baud_acc_t baud_q;
    logic                     tx_done_q;
    logic                     bvalid_q;
    logic                     rvalid_q;
    uart_reg_pkg::axil_resp_t bresp_q;
    uart_reg_pkg::axil_resp_t rresp_q;
    uart_reg_pkg::axil_data_t rdata_q;
    uart_reg_pkg::status_t    status;
    logic                     wr_accept;
    logic                     rd_accept;
    logic                     wr_hit_ctrl;
    logic                     wr_hit_baud;
    logic                     wr_hit_status;
    logic                     wr_hit_txdata;
    uart_reg_pkg::axil_resp_t wr_resp;
    uart_reg_pkg::axil_data_t rd_data;
    uart_reg_pkg::axil_resp_t rd_resp;

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////

    // address and data are taken together, one write in flight
    assign wr_accept   = s_awvalid_i && s_wvalid_i && !bvalid_q;
    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;

    assign wr_hit_ctrl   = (s_awaddr_i == `UART_OFS_CTRL);
    assign wr_hit_baud   = (s_awaddr_i == `UART_OFS_BAUD);
    assign wr_hit_status = (s_awaddr_i == `UART_OFS_STATUS);
    assign wr_hit_txdata = (s_awaddr_i == `UART_OFS_TXDATA);

    // a word offered to a full FIFO is dropped
    assign push_o      = wr_accept && wr_hit_txdata && !fifo_full_i;
    assign push_data_o = s_wdata_i[`UART_FRAME_W-1:0];

    always_comb begin
        wr_resp = uart_reg_pkg::RESP_OKAY;
        if (!(wr_hit_ctrl || wr_hit_baud || wr_hit_status || wr_hit_txdata)) begin
            wr_resp = uart_reg_pkg::RESP_SLVERR;
        end else if (wr_hit_txdata && fifo_full_i) begin
            wr_resp = uart_reg_pkg::RESP_SLVERR;
        end
    end

    ////////////////////////////////////////
    // read decode
    ////////////////////////////////////////

    assign rd_accept   = s_arvalid_i && !rvalid_q;
    assign s_arready_o = !rvalid_q;

    always_comb begin
        status = '0;
        status[uart_reg_pkg::STAT_FIFO_EMPTY] = fifo_empty_i;
        status[uart_reg_pkg::STAT_FIFO_FULL]  = fifo_full_i;
        status[uart_reg_pkg::STAT_BUSY]       = busy_i;
        status[uart_reg_pkg::STAT_TX_DONE]    = tx_done_q;
    end

    always_comb begin
        rd_data = '0;
        rd_resp = uart_reg_pkg::RESP_OKAY;
        case (s_araddr_i)
            `UART_OFS_CTRL:   rd_data[$bits(uart_reg_pkg::ctrl_t)-1:0] = ctrl_q;
            `UART_OFS_BAUD:   rd_data = baud_q;
            `UART_OFS_STATUS: rd_data[$bits(uart_reg_pkg::status_t)-1:0] = status;
            // data register is write only
            `UART_OFS_TXDATA: rd_data = '0;
            default:          rd_resp = uart_reg_pkg::RESP_SLVERR;
        endcase
    end

    ////////////////////////////////////////
    // registers and response state
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q    <= '0;
            baud_q    <= '0;
            tx_done_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (wr_accept && wr_hit_ctrl) begin
                ctrl_q <= s_wdata_i[$bits(uart_reg_pkg::ctrl_t)-1:0];
            end
            if (wr_accept && wr_hit_baud) begin
                baud_q <= s_wdata_i;
            end
            // a finishing frame wins over a clear in the same cycle
            if (frame_done_i) begin
                tx_done_q <= 1'b1;
            end else if (wr_accept && wr_hit_status
                         && s_wdata_i[uart_reg_pkg::STAT_TX_DONE]) begin
                tx_done_q <= 1'b0;
            end
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            bresp_q <= wr_resp;
        end
        if (rd_accept) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = bresp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rdata_o  = rdata_q;
    assign s_rresp_o  = rresp_q;
    assign ctrl_o     = ctrl_q;
    assign baud_o     = baud_q;

    // responses hold steady under back-pressure
    bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

    rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

// ==== logic/uart_line_pkg.sv ====
`include "uart_params.svh"

package uart_line_pkg;

    ////////////////////////////////////////
    // line framing types
    ////////////////////////////////////////

    // data word of one frame, bit 8 unused in 8-bit mode
    typedef logic [`UART_FRAME_W-1:0] frame_word_t;

    // phase accumulator and its increment
    // a carry out of the top bit marks one bit time
    typedef logic [31:0] baud_acc_t;

    // serializer states
    // START covers the wait for the first tick after the pop
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } tx_state_e;

endpackage

// ==== logic/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

`define UART_ADDR_W 4
`define UART_DATA_W 32

// widest data word, 9-bit mode
`define UART_FRAME_W 9

// transmit FIFO entries
`define UART_FIFO_DEPTH 4

////////////////////////////////////////
// register byte offsets
////////////////////////////////////////

`define UART_OFS_CTRL   4'h0
`define UART_OFS_BAUD   4'h4
`define UART_OFS_STATUS 4'h8
`define UART_OFS_TXDATA 4'hC

`endif

// ==== logic/uart_reg_pkg.sv ====
`include "uart_params.svh"

package uart_reg_pkg;

    ////////////////////////////////////////
    // AXI4-Lite bus types
    ////////////////////////////////////////

    typedef logic [`UART_ADDR_W-1:0] axil_addr_t;
    typedef logic [`UART_DATA_W-1:0] axil_data_t;
    typedef logic [1:0]              axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    ////////////////////////////////////////
    // control and status registers
    ////////////////////////////////////////

    typedef logic [3:0] ctrl_t;

    localparam int CTRL_TX_ENABLE  = 0;
    localparam int CTRL_NINE_BIT   = 1;
    localparam int CTRL_PARITY_EN  = 2;
    localparam int CTRL_PARITY_ODD = 3;

    typedef logic [3:0] status_t;

    localparam int STAT_FIFO_EMPTY = 0;
    localparam int STAT_FIFO_FULL  = 1;
    localparam int STAT_BUSY       = 2;
    // sticky, cleared by writing 1
    localparam int STAT_TX_DONE    = 3;

endpackage

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx_fifo (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       push_i,
    input  uart_line_pkg::frame_word_t push_data_i,
    input  logic                       pop_i,
    output uart_line_pkg::frame_word_t head_o,
    output logic                       empty_o,
    output logic                       full_o
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    uart_line_pkg::frame_word_t mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W:0]             count_q;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o  = mem[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));

    // the register block and the serializer check the flags
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> !full_o);

    no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o);

endmodule

// ==== logic/uart_tx_serializer.sv ====
`timescale 1ns/1ps

module uart_tx_serializer (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  uart_reg_pkg::ctrl_t        ctrl_i,
    input  uart_line_pkg::baud_acc_t   baud_i,
    input  logic                       fifo_empty_i,
    input  uart_line_pkg::frame_word_t head_i,
    output logic                       pop_o,
    output logic                       busy_o,
    output logic                       frame_done_o,
    output logic                       uart_tx_o
);

    localparam int ACC_W = $bits(uart_line_pkg::baud_acc_t);

    uart_line_pkg::tx_state_e   state_q;
    uart_line_pkg::baud_acc_t   acc_q;
    logic [ACC_W:0]             acc_sum;
    logic                       tick;
    logic [3:0]                 bit_cnt_q;
    logic [3:0]                 last_bit;
    uart_line_pkg::frame_word_t shift_q;
    uart_line_pkg::frame_word_t pop_word;
    logic                       nine_q;
    logic                       par_en_q;
    logic                       parity_q;
    logic                       tx_q;
    logic                       launch_data;

    ////////////////////////////////////////
    // baud generator
    ////////////////////////////////////////

    // carry out of the accumulator is the bit tick
    assign acc_sum = {1'b0, acc_q} + {1'b0, baud_i};
    assign tick    = acc_sum[ACC_W];

    ////////////////////////////////////////
    // frame control
    ////////////////////////////////////////

    assign pop_o = (state_q == uart_line_pkg::IDLE) && ctrl_i[uart_reg_pkg::CTRL_TX_ENABLE]
                   && !fifo_empty_i;

    // top bit is not sent in 8-bit mode, so keep it out of the parity
    always_comb begin
        pop_word = head_i;
        if (!ctrl_i[uart_reg_pkg::CTRL_NINE_BIT]) begin
            pop_word[$bits(pop_word)-1] = 1'b0;
        end
    end

    assign last_bit = nine_q ? 4'd8 : 4'd7;

    // start bit ending, or a data bit ending with more to go
    assign launch_data = tick && (((state_q == uart_line_pkg::START) && !tx_q)
                         || ((state_q == uart_line_pkg::DATA) && (bit_cnt_q != last_bit)));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q     <= '0;
            state_q   <= uart_line_pkg::IDLE;
            tx_q      <= 1'b1;
            bit_cnt_q <= '0;
        end else begin
            acc_q <= acc_sum[ACC_W-1:0];
            case (state_q)
                uart_line_pkg::IDLE: begin
                    if (pop_o) begin
                        state_q <= uart_line_pkg::START;
                    end
                end
                // line still high means the start bit has not begun yet
                uart_line_pkg::START: begin
                    if (tick && tx_q) begin
                        tx_q <= 1'b0;
                    end else if (launch_data) begin
                        tx_q      <= shift_q[0];
                        bit_cnt_q <= '0;
                        state_q   <= uart_line_pkg::DATA;
                    end
                end
                uart_line_pkg::DATA: begin
                    if (launch_data) begin
                        tx_q      <= shift_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end else if (tick && par_en_q) begin
                        tx_q    <= parity_q;
                        state_q <= uart_line_pkg::PARITY;
                    end else if (tick) begin
                        tx_q    <= 1'b1;
                        state_q <= uart_line_pkg::STOP;
                    end
                end
                uart_line_pkg::PARITY: begin
                    if (tick) begin
                        tx_q    <= 1'b1;
                        state_q <= uart_line_pkg::STOP;
                    end
                end
                uart_line_pkg::STOP: begin
                    if (tick) begin
                        state_q <= uart_line_pkg::IDLE;
                    end
                end
                default: state_q <= uart_line_pkg::IDLE;
            endcase
        end
    end

    // control fields are frozen at the pop for the whole frame
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift_q  <= pop_word;
            nine_q   <= ctrl_i[uart_reg_pkg::CTRL_NINE_BIT];
            par_en_q <= ctrl_i[uart_reg_pkg::CTRL_PARITY_EN];
            parity_q <= ^pop_word ^ ctrl_i[uart_reg_pkg::CTRL_PARITY_ODD];
        end else if (launch_data) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign busy_o       = (state_q != uart_line_pkg::IDLE);
    assign frame_done_o = (state_q == uart_line_pkg::STOP) && tick;
    assign uart_tx_o    = tx_q;

    line_idle_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_q == uart_line_pkg::IDLE |-> uart_tx_o);

endmodule

// ==== logic/uart_tx_top.sv ====
`timescale 1ns/1ps

module uart_tx_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  uart_reg_pkg::axil_addr_t s_awaddr_i,
    input  logic                     s_awvalid_i,
    output logic                     s_awready_o,
    input  uart_reg_pkg::axil_data_t s_wdata_i,
    input  logic                     s_wvalid_i,
    output logic                     s_wready_o,
    output uart_reg_pkg::axil_resp_t s_bresp_o,
    output logic                     s_bvalid_o,
    input  logic                     s_bready_i,
    input  uart_reg_pkg::axil_addr_t s_araddr_i,
    input  logic                     s_arvalid_i,
    output logic                     s_arready_o,
    output uart_reg_pkg::axil_data_t s_rdata_o,
    output uart_reg_pkg::axil_resp_t s_rresp_o,
    output logic                     s_rvalid_o,
    input  logic                     s_rready_i,
    output logic                     uart_tx_o
);

    logic                       push;
    uart_line_pkg::frame_word_t push_data;
    logic                       pop;
    uart_line_pkg::frame_word_t head;
    logic                       fifo_empty;
    logic                       fifo_full;
    logic                       busy;
    logic                       frame_done;
    uart_reg_pkg::ctrl_t        ctrl;
    uart_line_pkg::baud_acc_t   baud;

    // register block produces frame words
    uart_axil_regs u_regs (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .busy_i       (busy),
        .frame_done_i (frame_done),
        .push_o       (push),
        .push_data_o  (push_data),
        .ctrl_o       (ctrl),
        .baud_o       (baud)
    );

    uart_tx_fifo u_fifo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    // serializer drains the FIFO onto the line
    uart_tx_serializer u_serializer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .ctrl_i       (ctrl),
        .baud_i       (baud),
        .fifo_empty_i (fifo_empty),
        .head_i       (head),
        .pop_o        (pop),
        .busy_o       (busy),
        .frame_done_o (frame_done),
        .uart_tx_o    (uart_tx_o)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // reset held low over two rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== tb/tb_uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_tx;

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          IDLE_POLLS     = 200;
    localparam int          BIT_CYCLES     = 16;
    // 2^28 gives one tick every 16 clocks
    localparam logic [31:0] BAUD_16        = 32'h1000_0000;
    localparam logic [31:0] ST_EMPTY       = 32'h1;
    localparam logic [31:0] ST_FULL        = 32'h2;
    localparam logic [31:0] ST_BUSY        = 32'h4;
    localparam logic [31:0] ST_DONE        = 32'h8;
    localparam logic [1:0]  OKAY           = 2'b00;
    localparam logic [1:0]  SLVERR         = 2'b10;

    logic                     clk;
    logic                     arst_n;
    uart_reg_pkg::axil_addr_t awaddr;
    logic                     awvalid;
    logic                     awready;
    uart_reg_pkg::axil_data_t wdata;
    logic                     wvalid;
    logic                     wready;
    uart_reg_pkg::axil_resp_t bresp;
    logic                     bvalid;
    logic                     bready;
    uart_reg_pkg::axil_addr_t araddr;
    logic                     arvalid;
    logic                     arready;
    uart_reg_pkg::axil_data_t rdata;
    uart_reg_pkg::axil_resp_t rresp;
    logic                     rvalid;
    logic                     rready;
    logic                     tx_line;
    int                       seed;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    uart_tx_top DUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .s_awaddr_i  (awaddr),
        .s_awvalid_i (awvalid),
        .s_awready_o (awready),
        .s_wdata_i   (wdata),
        .s_wvalid_i  (wvalid),
        .s_wready_o  (wready),
        .s_bresp_o   (bresp),
        .s_bvalid_o  (bvalid),
        .s_bready_i  (bready),
        .s_araddr_i  (araddr),
        .s_arvalid_i (arvalid),
        .s_arready_o (arready),
        .s_rdata_o   (rdata),
        .s_rresp_o   (rresp),
        .s_rvalid_o  (rvalid),
        .s_rready_i  (rready),
        .uart_tx_o   (tx_line)
    );

    ////////////////////////////////////////
    // checking and failure
    ////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // AXI4-Lite driver
    ////////////////////////////////////////

    task automatic write_offer(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
    endtask

    task automatic write_wait_accept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("write address and data acceptance");
            end
            @(negedge clk);
        end
        // transfer happens on this edge
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic write_resp(input logic [1:0] exp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!bvalid) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("write response valid");
            end
            @(negedge clk);
        end
        check("s_bresp_o", bresp, exp);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [1:0] exp);
        write_offer(addr, data);
        write_wait_accept();
        write_resp(exp);
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("read address acceptance");
            end
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!rvalid) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("read data valid");
            end
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check({name, " s_rresp_o"}, resp, exp_resp);
        check({name, " s_rdata_o"}, data, exp_data);
    endtask

    // poll status until the serializer is back in idle
    task automatic wait_idle();
        logic [31:0] st;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        axil_read(`UART_OFS_STATUS, st, resp);
        while (st & ST_BUSY) begin
            polls++;
            if (polls > IDLE_POLLS) begin
                report_timeout("busy to clear in the status register");
            end
            axil_read(`UART_OFS_STATUS, st, resp);
        end
    endtask

    ////////////////////////////////////////
    // line monitor
    ////////////////////////////////////////

    task automatic rx_frame(input int nbits, input logic par_en,
                            output logic [8:0] data, output logic par);
        int cycles;
        cycles = 0;
        data   = '0;
        par    = 1'b0;
        @(negedge clk);
        while (tx_line !== 1'b0) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("start bit on uart_tx_o");
            end
            @(negedge clk);
        end
        // move to the middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check("uart_tx_o start bit", tx_line, 1'b0);
        for (int i = 0; i < nbits; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            data[i] = tx_line;
        end
        if (par_en) begin
            repeat (BIT_CYCLES) @(negedge clk);
            par = tx_line;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check("uart_tx_o stop bit", tx_line, 1'b1);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_regs();
        @(negedge clk);
        check("uart_tx_o", tx_line, 1'b1);
        check("s_awready_o", awready, 1'b0);
        check("s_wready_o", wready, 1'b0);
        check("s_bvalid_o", bvalid, 1'b0);
        check("s_arready_o", arready, 1'b1);
        check("s_rvalid_o", rvalid, 1'b0);
        read_check(`UART_OFS_STATUS, ST_EMPTY, OKAY, "status");
        axil_write(`UART_OFS_CTRL, 32'hE, OKAY);
        read_check(`UART_OFS_CTRL, 32'hE, OKAY, "ctrl");
        axil_write(`UART_OFS_BAUD, BAUD_16, OKAY);
        read_check(`UART_OFS_BAUD, BAUD_16, OKAY, "baud");
        read_check(4'h2, 32'h0, SLVERR, "unmapped");
        // unmapped write must leave ctrl alone
        axil_write(4'h6, 32'hF, SLVERR);
        read_check(`UART_OFS_CTRL, 32'hE, OKAY, "ctrl");
        axil_write(`UART_OFS_CTRL, 32'h0, OKAY);
    endtask

    task automatic test_frame_8n1();
        logic [31:0] word;
        logic [8:0]  rx_data;
        logic        rx_par;
        word = $random(seed) & 32'hFF;
        axil_write(`UART_OFS_CTRL, 32'h1, OKAY);
        axil_write(`UART_OFS_TXDATA, word, OKAY);
        rx_frame(8, 1'b0, rx_data, rx_par);
        check("received data", rx_data, word[8:0]);
        wait_idle();
        read_check(`UART_OFS_STATUS, ST_EMPTY | ST_DONE, OKAY, "status");
        axil_write(`UART_OFS_STATUS, ST_DONE, OKAY);
        read_check(`UART_OFS_STATUS, ST_EMPTY, OKAY, "status");
    endtask

    task automatic test_parity();
        logic [31:0] word;
        logic [8:0]  exp_data;
        logic        exp_par;
        logic [8:0]  rx_data;
        logic        rx_par;
        logic        nine;
        logic        odd;
        for (int mode = 0; mode < 4; mode++) begin
            nine = mode[1];
            odd  = mode[0];
            word = $random(seed);
            // both values of bit 8 get carried in 9-bit mode
            if (nine) begin
                word[8] = !odd;
            end
            exp_data = nine ? word[8:0] : {1'b0, word[7:0]};
            exp_par  = (^exp_data) ^ odd;
            axil_write(`UART_OFS_CTRL, {28'h0, odd, 1'b1, nine, 1'b1}, OKAY);
            axil_write(`UART_OFS_TXDATA, word, OKAY);
            rx_frame(nine ? 9 : 8, 1'b1, rx_data, rx_par);
            check("received data", rx_data, exp_data);
            check("received parity", rx_par, exp_par);
            wait_idle();
        end
    endtask

    task automatic test_fifo_full();
        logic [31:0] words [4];
        logic [8:0]  rx_data;
        logic        rx_par;
        axil_write(`UART_OFS_CTRL, 32'h0, OKAY);
        axil_write(`UART_OFS_STATUS, ST_DONE, OKAY);
        for (int i = 0; i < 4; i++) begin
            words[i] = $random(seed) & 32'hFF;
            axil_write(`UART_OFS_TXDATA, words[i], OKAY);
        end
        axil_write(`UART_OFS_TXDATA, 32'h5A, SLVERR);
        read_check(`UART_OFS_STATUS, ST_FULL, OKAY, "status");
        axil_write(`UART_OFS_CTRL, 32'h1, OKAY);
        for (int i = 0; i < 4; i++) begin
            rx_frame(8, 1'b0, rx_data, rx_par);
            check("received data", rx_data, words[i][8:0]);
        end
        wait_idle();
        read_check(`UART_OFS_STATUS, ST_EMPTY | ST_DONE, OKAY, "status");
    endtask

    task automatic test_back_pressure();
        write_offer(`UART_OFS_CTRL, 32'h0);
        write_wait_accept();
        // second write waits behind the held response
        write_offer(4'h2, 32'h3);
        repeat (10) begin
            @(negedge clk);
            check("s_bvalid_o", bvalid, 1'b1);
            check("s_awready_o", awready, 1'b0);
            check("s_wready_o", wready, 1'b0);
        end
        write_resp(OKAY);
        write_wait_accept();
        write_resp(SLVERR);
    endtask

    initial begin
        int cycles;
        seed    = 62888;
        cycles  = 0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        @(negedge clk);
        while (arst_n !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("reset release");
            end
            @(negedge clk);
        end
        test_reset_regs();
        test_frame_8n1();
        test_parity();
        test_fifo_full();
        test_back_pressure();
        $display(">>> PASS");
        $finish;
    end

endmodule
